/* sim.f */
+incdir+source
source/ppu_pixel_pkg.sv
source/ppu_apb_pkg.sv
source/sprite_pixel_shifter.sv
source/sprite_attr_shifter.sv
source/sprite_fetch_ctrl.sv
source/pixel_mixer.sv
source/ppu_apb_regs.sv
source/ppu_sprite_pipe.sv
tests/tb_clock_gen.sv
tests/ppu_sprite_pipe_tb.sv

/* tests/ppu_sprite_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ppu_config.svh"

module ppu_sprite_pipe_tb
	import ppu_pixel_pkg::*;
	import ppu_apb_pkg::*;
();

	typedef struct packed {
		color_idx_t color;
		spr_attr_t  attr;
	} slot_t;

	localparam int PIX_TOTAL = 16 + 16 + 8 + 11 + 24;

	logic        clkpipe;
	logic        arst_n;
	sprite_req_t spr_req;
	logic        spr_valid;
	logic        spr_ready;
	bg_pix_t     bg_pix;
	logic        bg_valid;
	logic        bg_ready;
	out_pix_t    out_pix;
	logic        out_valid;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;

	// Model of the eight sprite slots, head at the top index.
	slot_t       mdl [SPR_W] = '{default: '0};
	sprite_req_t pend_req;
	int          fetch_cnt = 0;
	logic        m_spr_en = 1'b0;
	palette_t    m_bgp = '0;
	palette_t    m_obp0 = '0;
	palette_t    m_obp1 = '0;
	apb_rsp_t    rsp_q;
	logic        last_bg_xfer;
	logic        last_spr_xfer;
	int          out_cnt = 0;
	int          checks = 0;
	int          errors = 0;
	int          chk0;
	int          err0;

	tb_clock_gen tb_clock_gen_i (.clkpipe(clkpipe), .arst_n(arst_n));

	ppu_sprite_pipe ppu_sprite_pipe_i (
		.clkpipe(clkpipe), .arst_n(arst_n), .spr_req(spr_req), .spr_valid(spr_valid),
		.bg_pix(bg_pix), .bg_valid(bg_valid), .apb_req(apb_req), .spr_ready(spr_ready),
		.bg_ready(bg_ready), .out_pix(out_pix), .out_valid(out_valid), .apb_rsp(apb_rsp)
	);

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic open_test();
		chk0 = checks;
		err0 = errors;
	endtask

	task automatic close_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
	endtask

	// One clock cycle, called on a falling edge after the inputs are driven.
	// fetch_cnt is 1 and 2 in the latch cycles and 3 in the load cycle.
	task automatic tick();
		logic       bg_xfer;
		logic       spr_win;
		slot_t      head;
		palette_t   pal;
		color_idx_t idx;
		logic [1:0] shade;
		int         k;
		#1;
		check_eq("spr_ready", spr_ready, fetch_cnt == 0);
		check_eq("bg_ready", bg_ready, fetch_cnt != 3);
		rsp_q = apb_rsp;
		bg_xfer = bg_valid && (fetch_cnt != 3);
		last_spr_xfer = spr_valid && (fetch_cnt == 0);
		head = mdl[SPR_W-1];
		spr_win = m_spr_en && (head.color != 0) &&
			(!head.attr.behind_bg || (bg_pix.color == 0));
		pal = spr_win ? (head.attr.pal_sel ? m_obp1 : m_obp0) : m_bgp;
		idx = spr_win ? head.color : bg_pix.color;
		shade = 2'(pal >> (2 * idx));
		@(negedge clkpipe);
		check_eq("out_valid", out_valid, bg_xfer);
		if (bg_xfer && out_valid) begin
			check_eq("out_pix.shade", out_pix.shade, shade);
			check_eq("out_pix.from_sprite", out_pix.from_sprite, spr_win);
		end
		out_cnt += out_valid;
		if (fetch_cnt == 3) begin
			// Only transparent slots take the new sprite.
			for (int j = 0; j < SPR_W; j++) begin
				k = pend_req.x_flip ? SPR_W - 1 - j : j;
				if (mdl[j].color == 0) begin
					mdl[j].color = {pend_req.plane_hi[k], pend_req.plane_lo[k]};
					mdl[j].attr = '{pal_sel: pend_req.pal_sel, behind_bg: pend_req.behind_bg};
				end
			end
		end else if (bg_xfer) begin
			for (int j = SPR_W - 1; j > 0; j--) begin
				mdl[j] = mdl[j-1];
			end
			mdl[0] = '0;
		end
		if (last_spr_xfer) begin
			pend_req = spr_req;
			fetch_cnt = 1;
		end else if (fetch_cnt != 0) begin
			fetch_cnt = (fetch_cnt + 1) % 4;
		end
		last_bg_xfer = bg_xfer;
	endtask

	task automatic apb_cycle(input logic wr, input logic [`PPU_APB_ADDR_W-1:0] addr,
		input logic [`PPU_APB_DATA_W-1:0] data, input logic exp_err);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
		tick();
		apb_req.penable = 1'b1;
		tick();
		apb_req = '0;
		check_eq("pready", rsp_q.pready, 1'b1);
		check_eq("pslverr", rsp_q.pslverr, exp_err);
	endtask

	task automatic apb_write(input logic [`PPU_APB_ADDR_W-1:0] addr,
		input logic [`PPU_APB_DATA_W-1:0] data, input logic exp_err);
		apb_cycle(1'b1, addr, data, exp_err);
		if (!exp_err) begin
			case (addr)
				`PPU_REG_CTRL: m_spr_en = data[0];
				`PPU_REG_BGP:  m_bgp = data[7:0];
				`PPU_REG_OBP0: m_obp0 = data[7:0];
				`PPU_REG_OBP1: m_obp1 = data[7:0];
				default: ;
			endcase
		end
	endtask

	task automatic apb_read(input logic [`PPU_APB_ADDR_W-1:0] addr,
		input logic [`PPU_APB_DATA_W-1:0] exp, input logic exp_err);
		apb_cycle(1'b0, addr, '0, exp_err);
		if (!exp_err) begin
			check_eq("prdata", rsp_q.prdata, exp);
		end
	endtask

	function automatic sprite_req_t rand_sprite(input logic flip, input logic pal, input logic behind);
		return '{plane_lo: 8'($urandom), plane_hi: 8'($urandom), x_flip: flip,
			pal_sel: pal, behind_bg: behind};
	endfunction

	task automatic send_sprite(input sprite_req_t req);
		spr_req = req;
		spr_valid = 1'b1;
		tick();
		while (!last_spr_xfer) begin
			tick();
		end
		spr_valid = 1'b0;
		while (fetch_cnt != 0) begin
			tick();
		end
	endtask

	// Streams n pixels back to back. A sprite joins at pixel spr_at, if that is not negative.
	task automatic send_bg_row(input int n, input int spr_at, input sprite_req_t req);
		int sent;
		int outs;
		sent = 0;
		outs = out_cnt;
		bg_valid = 1'b1;
		bg_pix.color = 2'($urandom);
		while (sent < n) begin
			if (sent == spr_at) begin
				spr_req = req;
				spr_valid = 1'b1;
			end
			tick();
			if (last_spr_xfer) begin
				spr_valid = 1'b0;
			end
			if (last_bg_xfer) begin
				sent++;
				bg_pix.color = 2'($urandom);
			end
		end
		bg_valid = 1'b0;
		while (fetch_cnt != 0) begin
			tick();
		end
		check_eq("output pixel count", out_cnt - outs, n);
	endtask

	task automatic test_registers();
		logic [`PPU_APB_ADDR_W-1:0] offs [3];
		logic [`PPU_APB_DATA_W-1:0] wd;
		open_test();
		offs = '{`PPU_REG_BGP, `PPU_REG_OBP0, `PPU_REG_OBP1};
		apb_read(`PPU_REG_CTRL, 32'h0, 1'b0);
		apb_read(`PPU_REG_STATUS, 32'h0, 1'b0);
		foreach (offs[i]) begin
			apb_read(offs[i], 32'h0, 1'b0);
		end
		apb_write(`PPU_REG_CTRL, 32'h1, 1'b0);
		apb_read(`PPU_REG_CTRL, 32'h1, 1'b0);
		foreach (offs[i]) begin
			wd = $urandom;
			apb_write(offs[i], wd, 1'b0);
			apb_read(offs[i], {24'h0, wd[7:0]}, 1'b0);
		end
		apb_write(`PPU_REG_STATUS, 32'h1, 1'b1);
		apb_read(8'h14, 32'h0, 1'b1);
		apb_write(8'h40, 32'hff, 1'b1);
		close_test("register access");
	endtask

	task automatic test_bg_only();
		open_test();
		apb_write(`PPU_REG_CTRL, 32'h0, 1'b0);
		apb_write(`PPU_REG_BGP, $urandom, 1'b0);
		send_sprite(rand_sprite(1'b0, 1'b0, 1'b0));
		send_bg_row(16, -1, '0);
		close_test("background only");
	endtask

	task automatic test_sprite_order();
		open_test();
		apb_write(`PPU_REG_CTRL, 32'h1, 1'b0);
		apb_write(`PPU_REG_OBP0, $urandom, 1'b0);
		apb_write(`PPU_REG_OBP1, $urandom, 1'b0);
		send_sprite(rand_sprite(1'b0, 1'b0, 1'b0));
		send_bg_row(8, -1, '0);
		send_sprite(rand_sprite(1'b1, 1'b1, 1'b0));
		send_bg_row(8, -1, '0);
		close_test("sprite order and flip");
	endtask

	task automatic test_priority();
		open_test();
		send_sprite(rand_sprite(1'b0, 1'b1, 1'b1));
		send_bg_row(8, -1, '0);
		close_test("behind-background priority");
	endtask

	task automatic test_overlap();
		open_test();
		// Mirrored palettes, so a wrong attribute shows up as a wrong shade.
		apb_write(`PPU_REG_OBP0, 32'hE4, 1'b0);
		apb_write(`PPU_REG_OBP1, 32'h1B, 1'b0);
		send_sprite(rand_sprite(1'b0, 1'b0, 1'b0));
		send_bg_row(3, -1, '0);
		send_sprite(rand_sprite(1'b1, 1'b1, 1'b0));
		send_bg_row(8, -1, '0);
		close_test("overlap masking");
	endtask

	task automatic test_backpressure();
		open_test();
		spr_req = rand_sprite(1'b0, 1'b0, 1'b0);
		spr_valid = 1'b1;
		tick();
		spr_valid = 1'b0;
		apb_read(`PPU_REG_STATUS, 32'h1, 1'b0);
		while (fetch_cnt != 0) begin
			tick();
		end
		apb_read(`PPU_REG_STATUS, 32'h0, 1'b0);
		send_bg_row(24, 5, rand_sprite(1'b1, 1'b1, 1'b0));
		close_test("back-pressure");
	endtask

	initial begin
		spr_req = '0;
		spr_valid = 1'b0;
		bg_pix = '0;
		bg_valid = 1'b0;
		apb_req = '0;
		void'($urandom(32'h80d0_324d));
		wait (arst_n === 1'b1);
		@(negedge clkpipe);
		test_registers();
		test_bg_only();
		test_sprite_order();
		test_priority();
		test_overlap();
		test_backpressure();
		$display("tests run: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// 200 cycles per pixel plus 1000 cycles of setup, at 8 ns per cycle.
	initial begin
		#((200 * PIX_TOTAL + 1000) * 8);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clkpipe,
	output logic arst_n
);

	// 8 ns period. Reset is released on a falling edge after two cycles.
	initial begin
		clkpipe = 1'b0;
		forever begin
			#4 clkpipe = ~clkpipe;
		end
	end

	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clkpipe);
		@(negedge clkpipe);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* source/ppu_sprite_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module ppu_sprite_pipe
	import ppu_pixel_pkg::*;
	import ppu_apb_pkg::*;
(
	input  logic        clkpipe,
	input  logic        arst_n,
	input  sprite_req_t spr_req,
	input  logic        spr_valid,
	input  bg_pix_t     bg_pix,
	input  logic        bg_valid,
	input  apb_req_t    apb_req,
	output logic        spr_ready,
	output logic        bg_ready,
	output out_pix_t    out_pix,
	output logic        out_valid,
	output apb_rsp_t    apb_rsp
);

	logic [SPR_W-1:0] plane_byte;
	logic [SPR_W-1:0] load_mask;
	logic [SPR_W-1:0] spr_plane_a;
	logic [SPR_W-1:0] spr_plane_b;
	logic             x_flip;
	logic             latch_lo;
	logic             latch_hi;
	logic             load;
	logic             fetch_busy;
	logic             advance;
	spr_attr_t        attr;
	spr_attr_t        spr_head_attr;
	color_idx_t       spr_head;
	logic             spr_en;
	palette_t         bgp;
	palette_t         obp0;
	palette_t         obp1;

	// The load cycle stalls the pixel stream, so loading and shifting never meet.
	assign bg_ready = !load;
	assign advance  = bg_valid && bg_ready;
	assign spr_head = {spr_plane_a[SPR_W-1], spr_plane_b[SPR_W-1]};

	sprite_fetch_ctrl sprite_fetch_ctrl_i (
		.clkpipe(clkpipe), .arst_n(arst_n),
		.spr_req(spr_req), .spr_valid(spr_valid),
		.spr_plane_a(spr_plane_a), .spr_plane_b(spr_plane_b),
		.spr_ready(spr_ready), .plane_byte(plane_byte), .x_flip(x_flip),
		.latch_lo(latch_lo), .latch_hi(latch_hi), .load(load),
		.load_mask(load_mask), .attr(attr), .busy(fetch_busy)
	);

	sprite_pixel_shifter sprite_pixel_shifter_i (
		.clkpipe(clkpipe), .arst_n(arst_n),
		.plane_byte(plane_byte), .x_flip(x_flip),
		.latch_lo(latch_lo), .latch_hi(latch_hi), .load(load),
		.load_mask(load_mask), .shift(advance),
		.spr_plane_a(spr_plane_a), .spr_plane_b(spr_plane_b)
	);

	sprite_attr_shifter sprite_attr_shifter_i (
		.clkpipe(clkpipe), .arst_n(arst_n),
		.load(load), .load_mask(load_mask), .shift(advance),
		.attr(attr), .head_attr(spr_head_attr)
	);

	pixel_mixer pixel_mixer_i (
		.clkpipe(clkpipe), .arst_n(arst_n),
		.bg_pix(bg_pix), .advance(advance),
		.spr_head(spr_head), .spr_attr(spr_head_attr),
		.spr_en(spr_en), .bgp(bgp), .obp0(obp0), .obp1(obp1),
		.out_pix(out_pix), .out_valid(out_valid)
	);

	ppu_apb_regs ppu_apb_regs_i (
		.clkpipe(clkpipe), .arst_n(arst_n),
		.apb_req(apb_req), .fetch_busy(fetch_busy), .apb_rsp(apb_rsp),
		.spr_en(spr_en), .bgp(bgp), .obp0(obp0), .obp1(obp1)
	);

endmodule

`default_nettype wire

/* source/ppu_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ppu_config.svh"

module ppu_apb_regs
	import ppu_pixel_pkg::*;
	import ppu_apb_pkg::*;
(
	input  logic     clkpipe,
	input  logic     arst_n,
	input  apb_req_t apb_req,
	input  logic     fetch_busy,
	output apb_rsp_t apb_rsp,
	output logic     spr_en,
	output palette_t bgp,
	output palette_t obp0,
	output palette_t obp1
);

	reg_sel_t sel;
	logic     access;
	logic     wr;

	always_comb begin
		case (apb_req.paddr)
			`PPU_REG_CTRL:   sel = REG_CTRL;
			`PPU_REG_BGP:    sel = REG_BGP;
			`PPU_REG_OBP0:   sel = REG_OBP0;
			`PPU_REG_OBP1:   sel = REG_OBP1;
			`PPU_REG_STATUS: sel = REG_STATUS;
			default:         sel = REG_NONE;
		endcase
	end

	// Zero wait states, so every access phase completes.
	assign access = apb_req.psel && apb_req.penable;
	assign wr     = access && apb_req.pwrite;

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			spr_en <= 1'b0;
			bgp    <= '0;
			obp0   <= '0;
			obp1   <= '0;
		end else if (wr) begin
			case (sel)
				REG_CTRL: spr_en <= apb_req.pwdata[`PPU_CTRL_SPR_EN_BIT];
				REG_BGP:  bgp    <= apb_req.pwdata[7:0];
				REG_OBP0: obp0   <= apb_req.pwdata[7:0];
				REG_OBP1: obp1   <= apb_req.pwdata[7:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		apb_rsp.prdata = '0;
		case (sel)
			REG_CTRL:   apb_rsp.prdata[`PPU_CTRL_SPR_EN_BIT] = spr_en;
			REG_BGP:    apb_rsp.prdata = `PPU_APB_DATA_W'(bgp);
			REG_OBP0:   apb_rsp.prdata = `PPU_APB_DATA_W'(obp0);
			REG_OBP1:   apb_rsp.prdata = `PPU_APB_DATA_W'(obp1);
			REG_STATUS: apb_rsp.prdata[`PPU_STATUS_BUSY_BIT] = fetch_busy;
			default: ;
		endcase
	end

	// STATUS is read only.
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access &&
		((sel == REG_NONE) || (apb_req.pwrite && (sel == REG_STATUS)));

endmodule

`default_nettype wire

/* source/pixel_mixer.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_mixer
	import ppu_pixel_pkg::*;
(
	input  logic       clkpipe,
	input  logic       arst_n,
	input  bg_pix_t    bg_pix,
	input  logic       advance,
	input  color_idx_t spr_head,
	input  spr_attr_t  spr_attr,
	input  logic       spr_en,
	input  palette_t   bgp,
	input  palette_t   obp0,
	input  palette_t   obp1,
	output out_pix_t   out_pix,
	output logic       out_valid
);

	logic     spr_win;
	palette_t obp;
	out_pix_t pix_nxt;

	function automatic logic [1:0] pal_lookup(input palette_t pal, input color_idx_t idx);
		return pal[2*idx +: 2];
	endfunction

	// A behind-background sprite only shows through background color 0.
	assign spr_win = spr_en && (spr_head != 2'd0) &&
		(!spr_attr.behind_bg || (bg_pix.color == 2'd0));

	assign obp = spr_attr.pal_sel ? obp1 : obp0;

	always_comb begin
		pix_nxt.from_sprite = spr_win;
		if (spr_win) begin
			pix_nxt.shade = pal_lookup(obp, spr_head);
		end else begin
			pix_nxt.shade = pal_lookup(bgp, bg_pix.color);
		end
	end

	always_ff @(posedge clkpipe) begin
		if (advance) begin
			out_pix <= pix_nxt;
		end
	end

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= advance;
		end
	end

endmodule

`default_nettype wire

/* source/sprite_fetch_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module sprite_fetch_ctrl
	import ppu_pixel_pkg::*;
(
	input  logic             clkpipe,
	input  logic             arst_n,
	input  sprite_req_t      spr_req,
	input  logic             spr_valid,
	input  logic [SPR_W-1:0] spr_plane_a,
	input  logic [SPR_W-1:0] spr_plane_b,
	output logic             spr_ready,
	output logic [SPR_W-1:0] plane_byte,
	output logic             x_flip,
	output logic             latch_lo,
	output logic             latch_hi,
	output logic             load,
	output logic [SPR_W-1:0] load_mask,
	output spr_attr_t        attr,
	output logic             busy
);

	fetch_state_t state;
	fetch_state_t state_nxt;
	sprite_req_t  req_q;

	always_comb begin
		state_nxt = state;
		case (state)
			FETCH_IDLE: begin
				if (spr_valid) begin
					state_nxt = FETCH_LATCH_LO;
				end
			end
			FETCH_LATCH_LO: state_nxt = FETCH_LATCH_HI;
			FETCH_LATCH_HI: state_nxt = FETCH_LOAD;
			FETCH_LOAD:     state_nxt = FETCH_IDLE;
			default:        state_nxt = FETCH_IDLE;
		endcase
	end

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Only one request is in flight, so a single buffer is enough.
	always_ff @(posedge clkpipe) begin
		if (spr_valid && spr_ready) begin
			req_q <= spr_req;
		end
	end

	assign spr_ready = (state == FETCH_IDLE);
	assign busy      = (state != FETCH_IDLE);
	assign latch_lo  = (state == FETCH_LATCH_LO);
	assign latch_hi  = (state == FETCH_LATCH_HI);
	assign load      = (state == FETCH_LOAD);

	assign plane_byte = latch_hi ? req_q.plane_hi : req_q.plane_lo;
	assign x_flip     = req_q.x_flip;

	assign attr.pal_sel   = req_q.pal_sel;
	assign attr.behind_bg = req_q.behind_bg;

	// A slot is free where both planes hold 0, i.e. the pixel is transparent.
	// No shift happens in the load cycle, so the planes are stable here.
	assign load_mask = load ? ~(spr_plane_a | spr_plane_b) : '0;

endmodule

`default_nettype wire

/* source/sprite_attr_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module sprite_attr_shifter
	import ppu_pixel_pkg::*;
(
	input  logic             clkpipe,
	input  logic             arst_n,
	input  logic             load,
	input  logic [SPR_W-1:0] load_mask,
	input  logic             shift,
	input  spr_attr_t        attr,
	output spr_attr_t        head_attr
);

	// One attribute slot per pixel slot, head at the top index.
	spr_attr_t [SPR_W-1:0] slot;

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			slot <= '0;
		end else if (load) begin
			for (int i = 0; i < SPR_W; i++) begin
				if (load_mask[i]) begin
					slot[i] <= attr;
				end
			end
		end else if (shift) begin
			slot <= {slot[SPR_W-2:0], {$bits(spr_attr_t){1'b0}}};
		end
	end

	assign head_attr = slot[SPR_W-1];

endmodule

`default_nettype wire

/* source/sprite_pixel_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module sprite_pixel_shifter
	import ppu_pixel_pkg::*;
(
	input  logic             clkpipe,
	input  logic             arst_n,
	input  logic [SPR_W-1:0] plane_byte,
	input  logic             x_flip,
	input  logic             latch_lo,
	input  logic             latch_hi,
	input  logic             load,
	input  logic [SPR_W-1:0] load_mask,
	input  logic             shift,
	output logic [SPR_W-1:0] spr_plane_a,
	output logic [SPR_W-1:0] spr_plane_b
);

	logic [SPR_W-1:0] byte_in;
	logic [SPR_W-1:0] lat_lo;
	logic [SPR_W-1:0] lat_hi;

	// Slot 7 is the head. Unflipped, the byte's MSB lands there and leaves first.
	// With x-flip the byte is mirrored so its LSB leaves first.
	always_comb begin
		for (int i = 0; i < SPR_W; i++) begin
			byte_in[i] = x_flip ? plane_byte[SPR_W-1-i] : plane_byte[i];
		end
	end

	always_ff @(posedge clkpipe) begin
		if (latch_lo) begin
			lat_lo <= byte_in;
		end
		if (latch_hi) begin
			lat_hi <= byte_in;
		end
	end

	// Plane a carries the high bitplane, so it forms the color index MSB.
	// Unmasked slots keep the opaque pixels of an earlier sprite.
	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			spr_plane_a <= '0;
			spr_plane_b <= '0;
		end else if (load) begin
			spr_plane_a <= (spr_plane_a & ~load_mask) | (lat_hi & load_mask);
			spr_plane_b <= (spr_plane_b & ~load_mask) | (lat_lo & load_mask);
		end else if (shift) begin
			spr_plane_a <= {spr_plane_a[SPR_W-2:0], 1'b0};
			spr_plane_b <= {spr_plane_b[SPR_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* source/ppu_apb_pkg.sv */
`default_nettype none

`include "ppu_config.svh"

package ppu_apb_pkg;

	typedef struct packed {
		logic                       psel;
		logic                       penable;
		logic                       pwrite;
		logic [`PPU_APB_ADDR_W-1:0] paddr;
		logic [`PPU_APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`PPU_APB_DATA_W-1:0] prdata;
		logic                       pready;
		logic                       pslverr;
	} apb_rsp_t;

	// REG_NONE marks an offset outside the register map.
	typedef enum logic [2:0] {
		REG_CTRL,
		REG_BGP,
		REG_OBP0,
		REG_OBP1,
		REG_STATUS,
		REG_NONE
	} reg_sel_t;

endpackage

`default_nettype wire

/* source/ppu_pixel_pkg.sv */
`default_nettype none

package ppu_pixel_pkg;

	// One tile row is eight pixels wide.
	localparam int SPR_W = 8;

	// Color index 0 is transparent for sprites.
	typedef logic [1:0] color_idx_t;

	// Four 2-bit shades, index i at bits 2i+1..2i.
	typedef logic [7:0] palette_t;

	typedef struct packed {
		logic [SPR_W-1:0] plane_lo;
		logic [SPR_W-1:0] plane_hi;
		logic             x_flip;
		logic             pal_sel;
		logic             behind_bg;
	} sprite_req_t;

	typedef struct packed {
		logic pal_sel;
		logic behind_bg;
	} spr_attr_t;

	typedef struct packed {
		color_idx_t color;
	} bg_pix_t;

	typedef struct packed {
		logic [1:0] shade;
		logic       from_sprite;
	} out_pix_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_LATCH_LO,
		FETCH_LATCH_HI,
		FETCH_LOAD
	} fetch_state_t;

endpackage

`default_nettype wire

/* source/ppu_config.svh */
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// APB bus widths. The register map fits in one address byte.
`define PPU_APB_ADDR_W 8
`define PPU_APB_DATA_W 32

// Register byte offsets on the APB port.
`define PPU_REG_CTRL   8'h00
`define PPU_REG_BGP    8'h04
`define PPU_REG_OBP0   8'h08
`define PPU_REG_OBP1   8'h0C
`define PPU_REG_STATUS 8'h10

// CTRL bit 0 enables sprites, STATUS bit 0 shows a fetch in progress.
`define PPU_CTRL_SPR_EN_BIT 0
`define PPU_STATUS_BUSY_BIT 0

`endif
